// File: verilog/mldsa_norm_pkg.sv
//############################################################################
// ML-DSA norm check constants and check bounds, the check mode and
// controller state enums, memory request structs and the APB register map
//############################################################################
`default_nettype none

package mldsa_norm_pkg;

    // Modulus, stored as a 23-bit value like the coefficients
    localparam logic [22:0] mldsa_q = 23'd8380417;
    localparam int mldsa_n = 256;

    // Each coefficient sits in a 24-bit slot and only the low 23 bits carry data
    localparam int reg_size = 24;
    localparam int coeff_width = 23;
    localparam int lanes = 4;
    localparam int lane_sel_width = $clog2(lanes);
    localparam int polys_words = mldsa_n / lanes;
    localparam int word_cnt_width = $clog2(polys_words);
    localparam logic [word_cnt_width-1:0] last_word_idx = word_cnt_width'(polys_words - 1);

    localparam int mem_depth = 256;
    localparam int mem_addr_width = 8;

    // Bounds for each mode, with beta = 120
    // gamma1 = 2^19 for z, gamma2 = (q-1)/32 for r0 and ct0
    localparam logic [coeff_width-1:0] bound_z = 23'd524168;
    localparam logic [coeff_width-1:0] bound_r0 = 23'd261768;
    localparam logic [coeff_width-1:0] bound_ct0 = 23'd261888;

    // Values above this one are negative once centered around zero
    localparam logic [coeff_width-1:0] half_q = (mldsa_q - 23'd1) >> 1;

    typedef enum logic [1:0] {
        chk_z   = 2'd0,
        chk_r0  = 2'd1,
        chk_ct0 = 2'd2
    } chk_norm_mode_t;

    typedef enum logic [1:0] {
        idle,
        read,
        drain
    } ctrl_state_t;

    // Read request from the controller into the coefficient memory
    typedef struct packed {
        logic                      rd_en;
        logic [mem_addr_width-1:0] addr;
    } mem_if_t;

    // Single-lane write from the APB window
    typedef struct packed {
        logic                      wr_en;
        logic [mem_addr_width-1:0] addr;
        logic [lane_sel_width-1:0] lane;
        logic [reg_size-1:0]       data;
    } mem_wr_t;

    // APB register map
    localparam int apb_addr_width = 13;
    localparam logic [apb_addr_width-1:0] ctrl_offset = 13'h000;
    localparam logic [apb_addr_width-1:0] base_offset = 13'h004;
    localparam logic [apb_addr_width-1:0] status_offset = 13'h008;
    localparam logic [apb_addr_width-1:0] coeff_window_base = 13'h1000;

endpackage

`default_nettype wire

// File: verilog/norm_check.sv
//############################################################################
// Single coefficient norm check against the bound of the selected mode
//############################################################################
`default_nettype none

module norm_check (
    input  logic                                   enable,
    input  mldsa_norm_pkg::chk_norm_mode_t         mode,
    input  logic [mldsa_norm_pkg::coeff_width-1:0] opa,
    output logic                                   invalid
);

    logic [mldsa_norm_pkg::coeff_width-1:0] magnitude;
    logic [mldsa_norm_pkg::coeff_width-1:0] bound;

    // Centered magnitude, so q-x counts the same as x
    assign magnitude = (opa <= mldsa_norm_pkg::half_q) ? opa : (mldsa_norm_pkg::mldsa_q - opa);

    always_comb begin
        case (mode)
            mldsa_norm_pkg::chk_z:   bound = mldsa_norm_pkg::bound_z;
            mldsa_norm_pkg::chk_r0:  bound = mldsa_norm_pkg::bound_r0;
            mldsa_norm_pkg::chk_ct0: bound = mldsa_norm_pkg::bound_ct0;
            // Mode 3 is refused by the registers and never reaches here
            default:                 bound = mldsa_norm_pkg::bound_ct0;
        endcase
    end

    // A coefficient equal to the bound already fails
    assign invalid = enable & (magnitude >= bound);

endmodule

`default_nettype wire

// File: verilog/norm_check_ctrl.sv
//############################################################################
// Norm check controller FSM that streams one polynomial's read requests
// from the base address and signals done after the pipeline drains
//############################################################################
`default_nettype none

module norm_check_ctrl (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      zeroize,
    input  logic                                      start,
    input  logic [mldsa_norm_pkg::mem_addr_width-1:0] mem_base_addr,
    output mldsa_norm_pkg::mem_if_t                   mem_rd_req,
    output logic                                      check_enable,
    output logic                                      norm_check_done
);

    mldsa_norm_pkg::ctrl_state_t state;
    logic [mldsa_norm_pkg::word_cnt_width-1:0] word_cnt;
    logic last_word;

    assign last_word = (word_cnt == mldsa_norm_pkg::last_word_idx);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= mldsa_norm_pkg::idle;
            word_cnt        <= '0;
            norm_check_done <= 1'b0;
        end else if (zeroize) begin
            state           <= mldsa_norm_pkg::idle;
            word_cnt        <= '0;
            norm_check_done <= 1'b0;
        end else begin
            norm_check_done <= 1'b0;
            case (state)
                mldsa_norm_pkg::idle: begin
                    if (start) begin
                        state    <= mldsa_norm_pkg::read;
                        word_cnt <= '0;
                    end
                end
                mldsa_norm_pkg::read: begin
                    // Counter wraps back to zero after the last word
                    word_cnt <= word_cnt + 1'b1;
                    if (last_word) begin
                        state <= mldsa_norm_pkg::drain;
                    end
                end
                mldsa_norm_pkg::drain: begin
                    // Last word's data is being checked this cycle
                    // so its result sits in the accumulator when done shows
                    state           <= mldsa_norm_pkg::idle;
                    norm_check_done <= 1'b1;
                end
                default: begin
                    state <= mldsa_norm_pkg::idle;
                end
            endcase
        end
    end

    // One read per cycle in the read state, wrapping modulo the memory depth
    assign mem_rd_req.rd_en = (state == mldsa_norm_pkg::read);
    assign mem_rd_req.addr  = mem_base_addr + mldsa_norm_pkg::mem_addr_width'(word_cnt);

    // Lane enable leaves with the read strobe; the top lines it up with the data
    assign check_enable = mem_rd_req.rd_en;

endmodule

`default_nettype wire

// File: verilog/norm_check_top.sv
//############################################################################
// Four parallel check lanes with enable alignment, the sticky invalid
// accumulator and the ready delay after done
//############################################################################
`default_nettype none

module norm_check_top (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      zeroize,
    input  logic                                      start,
    input  mldsa_norm_pkg::chk_norm_mode_t            mode,
    input  logic [mldsa_norm_pkg::mem_addr_width-1:0] mem_base_addr,
    output mldsa_norm_pkg::mem_if_t                   mem_rd_req,
    input  logic [mldsa_norm_pkg::lanes*mldsa_norm_pkg::reg_size-1:0] mem_rd_data,
    output logic                                      invalid,
    output logic                                      norm_check_ready,
    output logic                                      norm_check_done
);

    logic check_enable;
    logic check_enable_q;
    logic [mldsa_norm_pkg::lanes-1:0] lane_invalid;

    norm_check_ctrl u_norm_check_ctrl (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize         (zeroize),
        .start           (start),
        .mem_base_addr   (mem_base_addr),
        .mem_rd_req      (mem_rd_req),
        .check_enable    (check_enable),
        .norm_check_done (norm_check_done)
    );

    // Each lane takes the low 23 bits of its 24-bit slot
    for (genvar i = 0; i < mldsa_norm_pkg::lanes; i++) begin : g_lane
        norm_check u_norm_check (
            .enable  (check_enable_q),
            .mode    (mode),
            .opa     (mem_rd_data[i*mldsa_norm_pkg::reg_size +: mldsa_norm_pkg::coeff_width]),
            .invalid (lane_invalid[i])
        );
    end

    // The memory answers one cycle after the request, so the enable waits one cycle too
    // Ready trails done by a cycle so the registers have captured invalid first
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            check_enable_q   <= 1'b0;
            norm_check_ready <= 1'b0;
        end else if (zeroize) begin
            check_enable_q   <= 1'b0;
            norm_check_ready <= 1'b0;
        end else begin
            check_enable_q   <= check_enable;
            norm_check_ready <= norm_check_done;
        end
    end

    // Any failing lane on any word makes the whole polynomial invalid
    // Clearing on done leaves the next check starting from zero
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            invalid <= 1'b0;
        end else if (zeroize || norm_check_done) begin
            invalid <= 1'b0;
        end else begin
            invalid <= invalid | (|lane_invalid);
        end
    end

endmodule

`default_nettype wire

// File: verilog/coeff_mem.sv
//############################################################################
// Coefficient memory with a single-lane write port and a registered read
//############################################################################
`default_nettype none

module coeff_mem (
    input  logic                      clk,
    input  mldsa_norm_pkg::mem_wr_t   wr,
    input  mldsa_norm_pkg::mem_if_t   rd_req,
    output logic [mldsa_norm_pkg::lanes*mldsa_norm_pkg::reg_size-1:0] rd_data
);

    // Four coefficient slots per word, lane 0 in the low bits
    logic [mldsa_norm_pkg::lanes*mldsa_norm_pkg::reg_size-1:0] mem [mldsa_norm_pkg::mem_depth];

    always_ff @(posedge clk) begin
        // A write touches one lane and leaves the other three slots of the word alone
        if (wr.wr_en) begin
            mem[wr.addr][wr.lane*mldsa_norm_pkg::reg_size +: mldsa_norm_pkg::reg_size] <= wr.data;
        end
        // Read data appears the cycle after the request
        if (rd_req.rd_en) begin
            rd_data <= mem[rd_req.addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/norm_check_apb_regs.sv
//############################################################################
// APB slave with the control, base and status registers and the
// write-only coefficient window into the memory
//############################################################################
`default_nettype none

module norm_check_apb_regs (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  logic [mldsa_norm_pkg::apb_addr_width-1:0] paddr,
    input  logic [31:0]                               pwdata,
    output logic [31:0]                               prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    input  logic                                      invalid,
    input  logic                                      norm_check_done,
    input  logic                                      norm_check_ready,
    output logic                                      start,
    output logic                                      zeroize,
    output mldsa_norm_pkg::chk_norm_mode_t            mode,
    output logic [mldsa_norm_pkg::mem_addr_width-1:0] mem_base_addr,
    output mldsa_norm_pkg::mem_wr_t                   mem_wr
);

    logic access;
    logic wr_access;
    logic sel_ctrl;
    logic sel_base;
    logic sel_status;
    logic sel_window;
    logic mode_bad;
    logic start_busy;
    logic ctrl_write_ok;
    logic start_req;
    logic zero_req;
    logic busy;
    logic done_sticky;
    logic invalid_q;

    // Every transfer completes in its access phase
    assign access    = psel & penable;
    assign wr_access = access & pwrite;
    assign pready    = 1'b1;

    assign sel_ctrl   = (paddr == mldsa_norm_pkg::ctrl_offset);
    assign sel_base   = (paddr == mldsa_norm_pkg::base_offset);
    assign sel_status = (paddr == mldsa_norm_pkg::status_offset);
    assign sel_window = (paddr >= mldsa_norm_pkg::coeff_window_base);

    // A refused CTRL write changes nothing, not even zeroize
    assign mode_bad      = (pwdata[3:2] == 2'd3);
    assign start_busy    = pwdata[0] & busy;
    assign ctrl_write_ok = wr_access & sel_ctrl & ~mode_bad & ~start_busy;
    assign zero_req      = ctrl_write_ok & pwdata[1];
    // Zeroize wins over a start in the same write
    assign start_req     = ctrl_write_ok & pwdata[0] & ~pwdata[1];

    assign pslverr = access & (~(sel_ctrl | sel_base | sel_status | sel_window)
                             | (pwrite & sel_ctrl & (mode_bad | start_busy)));

    // Start and zeroize leave as one-cycle pulses after the access phase
    // Mode and base stay frozen while a check runs
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start         <= 1'b0;
            zeroize       <= 1'b0;
            mode          <= mldsa_norm_pkg::chk_z;
            mem_base_addr <= '0;
        end else begin
            start   <= start_req;
            zeroize <= zero_req;
            if (ctrl_write_ok && !busy) begin
                mode <= mldsa_norm_pkg::chk_norm_mode_t'(pwdata[3:2]);
            end
            if (wr_access && sel_base && !busy) begin
                mem_base_addr <= pwdata[mldsa_norm_pkg::mem_addr_width-1:0];
            end
        end
    end

    // Status bits; busy rises with the start request and falls on ready
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy        <= 1'b0;
            done_sticky <= 1'b0;
            invalid_q   <= 1'b0;
        end else if (zero_req) begin
            busy        <= 1'b0;
            done_sticky <= 1'b0;
            invalid_q   <= 1'b0;
        end else begin
            if (start_req) begin
                busy        <= 1'b1;
                done_sticky <= 1'b0;
            end
            // Invalid is only meaningful in the done cycle
            if (norm_check_done) begin
                done_sticky <= 1'b1;
                invalid_q   <= invalid;
            end
            if (norm_check_ready) begin
                busy <= 1'b0;
            end
        end
    end

    // Slot k maps to word k/4 and lane k mod 4
    assign mem_wr.wr_en = wr_access & sel_window;
    assign mem_wr.lane  = paddr[2 +: mldsa_norm_pkg::lane_sel_width];
    assign mem_wr.addr  = paddr[2 + mldsa_norm_pkg::lane_sel_width +: mldsa_norm_pkg::mem_addr_width];
    assign mem_wr.data  = pwdata[mldsa_norm_pkg::reg_size-1:0];

    // The window reads back as zero
    always_comb begin
        prdata = '0;
        if (sel_ctrl) begin
            prdata[3:2] = mode;
        end else if (sel_base) begin
            prdata[mldsa_norm_pkg::mem_addr_width-1:0] = mem_base_addr;
        end else if (sel_status) begin
            prdata[2:0] = {invalid_q, done_sticky, busy};
        end
    end

endmodule

`default_nettype wire

// File: verilog/mldsa_norm_subsys.sv
//############################################################################
// Norm check subsystem top with the APB registers, coefficient memory
// and the four-lane check datapath
//############################################################################
`default_nettype none

module mldsa_norm_subsys (
    input  logic                                      clk,
    input  logic                                      reset_n,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  logic [mldsa_norm_pkg::apb_addr_width-1:0] paddr,
    input  logic [31:0]                               pwdata,
    output logic [31:0]                               prdata,
    output logic                                      pready,
    output logic                                      pslverr
);

    logic start;
    logic zeroize;
    logic invalid;
    logic norm_check_done;
    logic norm_check_ready;
    mldsa_norm_pkg::chk_norm_mode_t mode;
    logic [mldsa_norm_pkg::mem_addr_width-1:0] mem_base_addr;
    mldsa_norm_pkg::mem_wr_t mem_wr;
    mldsa_norm_pkg::mem_if_t mem_rd_req;
    logic [mldsa_norm_pkg::lanes*mldsa_norm_pkg::reg_size-1:0] mem_rd_data;

    norm_check_apb_regs u_norm_check_apb_regs (
        .clk              (clk),
        .reset_n          (reset_n),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .paddr            (paddr),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .invalid          (invalid),
        .norm_check_done  (norm_check_done),
        .norm_check_ready (norm_check_ready),
        .start            (start),
        .zeroize          (zeroize),
        .mode             (mode),
        .mem_base_addr    (mem_base_addr),
        .mem_wr           (mem_wr)
    );

    // APB writes and controller reads share the memory on separate ports
    coeff_mem u_coeff_mem (
        .clk     (clk),
        .wr      (mem_wr),
        .rd_req  (mem_rd_req),
        .rd_data (mem_rd_data)
    );

    norm_check_top u_norm_check_top (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (zeroize),
        .start            (start),
        .mode             (mode),
        .mem_base_addr    (mem_base_addr),
        .mem_rd_req       (mem_rd_req),
        .mem_rd_data      (mem_rd_data),
        .invalid          (invalid),
        .norm_check_ready (norm_check_ready),
        .norm_check_done  (norm_check_done)
    );

endmodule

`default_nettype wire

// File: testbench/norm_check_checker.sv
//############################################################################
// Concurrent assertions on the done and ready handshake, the read address
// stream and the clearing of the invalid accumulator
//############################################################################
`default_nettype none

module norm_check_checker (
    input logic                    clk,
    input logic                    reset_n,
    input logic                    zeroize,
    input mldsa_norm_pkg::mem_if_t mem_rd_req,
    input logic                    invalid,
    input logic                    norm_check_done,
    input logic                    norm_check_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // Failure count, read by the testbench top at the end of the run
    int fail_count = 0;

    // Ready trails done by one cycle unless a zeroize lands on that edge
    done_then_ready: assert property (@(posedge clk) disable iff (!reset_n)
        norm_check_done && !zeroize |=> norm_check_ready)
    else begin
        $error("ready did not follow done in the next cycle");
        fail_count++;
    end

    // Back-to-back reads always step to the next word, wrapping at the top
    read_addr_steps: assert property (@(posedge clk) disable iff (!reset_n)
        mem_rd_req.rd_en ##1 mem_rd_req.rd_en |->
        mem_rd_req.addr == mldsa_norm_pkg::mem_addr_width'($past(mem_rd_req.addr) + 1))
    else begin
        $error("consecutive reads without an address increment");
        fail_count++;
    end

    // The accumulator starts the next check from zero
    invalid_clear_after_done: assert property (@(posedge clk) disable iff (!reset_n)
        norm_check_done |=> !invalid)
    else begin
        $error("invalid still set in the cycle after done");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: testbench/tb_mldsa_norm_subsys.sv
//############################################################################
// Testbench for the norm check subsystem with APB tasks, a coefficient
// shadow, the reference model, a compare process, tests and a watchdog
//############################################################################
`default_nettype none

module tb_mldsa_norm_subsys;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 8;
    localparam int num_tests = 12;
    localparam int cycles_per_test = 2000;
    localparam int max_polls = 200;
    // ML-DSA values used by the reference model
    localparam int q = 8380417;
    localparam int beta = 120;
    localparam int gamma1 = 1 << 19;
    localparam int gamma2 = (q - 1) / 32;

    logic        clk;
    logic        reset_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [12:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Copy of every slot the testbench has written, 1024 slots in 256 words
    logic [23:0] shadow [1024];
    integer seed = 32'h253a;
    int errors = 0;
    int test_num = 0;
    int test_errors;
    string test_name;
    string name_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];

    mldsa_norm_subsys u_mldsa_norm_subsys (
        .clk     (clk),
        .reset_n (reset_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    bind norm_check_top norm_check_checker u_norm_check_checker (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (zeroize),
        .mem_rd_req       (mem_rd_req),
        .invalid          (invalid),
        .norm_check_done  (norm_check_done),
        .norm_check_ready (norm_check_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Run budget is the test count times the cycles allowed per test
    initial begin
        #(num_tests * cycles_per_test * clk_period);
        $display("Watchdog expired before all tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic int mode_bound(input int mode);
        case (mode)
            0:       return gamma1 - beta;
            1:       return gamma2 - beta;
            default: return gamma2;
        endcase
    endfunction

    // Expected invalid flag over the 256 slots from a base word, wrapping at word 255
    function automatic logic ref_invalid(input int mode, input int base);
        int v;
        int mag;
        logic inv;
        inv = 1'b0;
        for (int i = 0; i < 256; i++) begin
            v = int'(shadow[(base * 4 + i) % 1024][22:0]);
            // Values above (q-1)/2 stand for negative numbers
            mag = (v <= (q - 1) / 2) ? v : q - v;
            if (mag >= mode_bound(mode)) begin
                inv = 1'b1;
            end
        end
        return inv;
    endfunction

    function automatic void push_check(input string name, input logic [31:0] exp_val,
                                       input logic [31:0] act_val);
        name_q.push_back(name);
        exp_q.push_back(exp_val);
        // Actual goes last since the compare process waits on it
        act_q.push_back(act_val);
    endfunction

    // Compare process for every expected and actual pair posted by the tests
    initial begin
        string name;
        logic [31:0] exp_val;
        logic [31:0] act_val;
        forever begin
            wait (act_q.size() != 0);
            name = name_q.pop_front();
            exp_val = exp_q.pop_front();
            act_val = act_q.pop_front();
            assert (act_val === exp_val)
            else begin
                $display("FAILED %s %s expected %h actual %h",
                         test_name, name, exp_val, act_val);
                errors++;
            end
        end
    end

    // One APB transfer, outputs sampled mid-cycle in the access phase
    task automatic apb_xfer(input logic wr, input logic [12:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err = pslverr;
        // The slave never stretches a transfer beyond its access phase
        assert (pready === 1'b1)
        else begin
            $display("FAILED %s pready expected 1 actual %b", test_name, pready);
            errors++;
        end
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [12:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic err;
        apb_xfer(1'b1, addr, data, rdata, err);
        assert (!err)
        else begin
            $display("Unexpected slave error on a write to address %h", addr);
            errors++;
        end
    endtask

    task automatic apb_read(input logic [12:0] addr, output logic [31:0] rdata);
        logic err;
        apb_xfer(1'b0, addr, 32'h0, rdata, err);
        assert (!err)
        else begin
            $display("Unexpected slave error on a read from address %h", addr);
            errors++;
        end
    endtask

    // Slot k sits at 0x1000 + 4k
    task automatic set_slot(input int slot, input int value);
        shadow[slot] = 24'(value);
        apb_write(13'h1000 + 13'(slot * 4), 32'(value));
    endtask

    // Random magnitudes below limit with a random sign, stored mod q
    task automatic fill_poly(input int base, input int limit);
        int mag;
        logic neg;
        for (int i = 0; i < 256; i++) begin
            mag = $unsigned($random(seed)) % limit;
            neg = $random(seed) & 1;
            if (neg && mag != 0) begin
                mag = q - mag;
            end
            set_slot((base * 4 + i) % 1024, mag);
        end
    endtask

    // Polls until done is set and busy has dropped, then posts the status
    task automatic finish_check(input string name, input int mode, input int base);
        logic [31:0] status;
        int polls;
        status = '0;
        polls = 0;
        while (!(status[1] && !status[0]) && polls < max_polls) begin
            apb_read(13'h008, status);
            polls++;
        end
        assert (status[1] && !status[0]) begin
            push_check(name, {29'h0, ref_invalid(mode, base), 2'b10}, {29'h0, status[2:0]});
        end else begin
            $display("Check %s did not finish within %0d status polls", name, max_polls);
            errors++;
        end
    endtask

    task automatic run_check(input string name, input int mode, input int base);
        apb_write(13'h004, 32'(base));
        apb_write(13'h000, 32'((mode << 2) | 1));
        finish_check(name, mode, base);
    endtask

    // Bound and bound minus one in every lane of the first and last word
    task automatic bound_sweep(input int mode);
        int slots [8] = '{0, 1, 2, 3, 252, 253, 254, 255};
        int keep;
        foreach (slots[k]) begin
            keep = int'(shadow[slots[k]]);
            set_slot(slots[k], mode_bound(mode));
            run_check($sformatf("bound_m%0d_slot%0d", mode, slots[k]), mode, 0);
            set_slot(slots[k], mode_bound(mode) - 1);
            run_check($sformatf("below_m%0d_slot%0d", mode, slots[k]), mode, 0);
            set_slot(slots[k], keep);
        end
    endtask

    task automatic begin_test(input string name);
        test_num++;
        test_name = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        wait (act_q.size() == 0);
        @(negedge clk);
        if (errors == test_errors) begin
            $display("Test %0d %s: ok", test_num, test_name);
        end else begin
            $display("Test %0d %s: %0d errors", test_num, test_name, errors - test_errors);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic err;
        int fails;
        reset_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (5) @(negedge clk);
        reset_n = 1'b1;

        // Small values and values near q that center to small negatives
        begin_test("small_all_modes");
        fill_poly(0, 1001);
        set_slot(5, q - 1);
        set_slot(6, 1);
        run_check("small_z", 0, 0);
        run_check("small_r0", 1, 0);
        run_check("small_ct0", 2, 0);
        end_test();

        begin_test("bound_z");
        bound_sweep(0);
        end_test();
        begin_test("bound_r0");
        bound_sweep(1);
        end_test();
        begin_test("bound_ct0");
        bound_sweep(2);
        end_test();

        // 261800 lies between the r0 and ct0 bounds, also as q minus it
        begin_test("centering");
        set_slot(10, 261800);
        for (int m = 0; m < 3; m++) begin
            run_check($sformatf("center_pos_m%0d", m), 2 - m, 0);
        end
        set_slot(10, q - 261800);
        for (int m = 0; m < 3; m++) begin
            run_check($sformatf("center_neg_m%0d", m), 2 - m, 0);
        end
        set_slot(10, 0);
        end_test();

        begin_test("random_base_17");
        fill_poly(17, 262000);
        for (int m = 0; m < 3; m++) begin
            run_check($sformatf("rand17_m%0d", m), m, 17);
        end
        end_test();

        // Base 240 wraps past word 255 into word 0
        begin_test("random_base_240");
        fill_poly(240, 262000);
        for (int m = 0; m < 3; m++) begin
            run_check($sformatf("rand240_m%0d", m), m, 240);
        end
        end_test();

        begin_test("back_to_back");
        set_slot(100, q - (gamma1 - beta));
        run_check("b2b_fail", 0, 0);
        set_slot(100, 0);
        run_check("b2b_pass", 0, 0);
        end_test();

        begin_test("zeroize_mid_check");
        apb_write(13'h000, 32'h1);
        repeat (10) @(negedge clk);
        apb_write(13'h000, 32'h2);
        apb_read(13'h008, rdata);
        push_check("zeroize_status", 32'h0, rdata);
        // No late done may appear once the pipeline has been cleared
        repeat (100) @(negedge clk);
        apb_read(13'h008, rdata);
        push_check("zeroize_quiet", 32'h0, rdata);
        end_test();

        begin_test("bad_mode");
        apb_write(13'h000, 32'h8);
        apb_xfer(1'b1, 13'h000, 32'hC, rdata, err);
        push_check("bad_mode_err", 32'h1, {31'h0, err});
        apb_read(13'h000, rdata);
        push_check("bad_mode_keep", 32'h8, rdata);
        end_test();

        begin_test("unmapped_addr");
        apb_write(13'h004, 32'h5);
        apb_xfer(1'b0, 13'h00C, 32'h0, rdata, err);
        push_check("unmapped_read_err", 32'h1, {31'h0, err});
        apb_xfer(1'b1, 13'h800, 32'h55, rdata, err);
        push_check("unmapped_write_err", 32'h1, {31'h0, err});
        apb_read(13'h004, rdata);
        push_check("unmapped_base_keep", 32'h5, rdata);
        end_test();

        // A second start with another mode is refused and the first check completes
        begin_test("start_while_busy");
        apb_write(13'h004, 32'h0);
        apb_write(13'h000, 32'h1);
        apb_xfer(1'b1, 13'h000, 32'h5, rdata, err);
        push_check("busy_start_err", 32'h1, {31'h0, err});
        apb_read(13'h000, rdata);
        push_check("busy_mode_keep", 32'h0, rdata);
        finish_check("busy_result", 0, 0);
        end_test();

        fails = u_mldsa_norm_subsys.u_norm_check_top.u_norm_check_checker.fail_count;
        $display("Tests run %0d, failed checks %0d, assertion failures %0d",
                 test_num, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/mldsa_norm_pkg.sv
verilog/norm_check.sv
verilog/norm_check_ctrl.sv
verilog/norm_check_top.sv
verilog/coeff_mem.sv
verilog/norm_check_apb_regs.sv
verilog/mldsa_norm_subsys.sv
testbench/norm_check_checker.sv
testbench/tb_mldsa_norm_subsys.sv

// File: Bender.yml
package:
  name: mldsa_norm_subsys

sources:
  - verilog/mldsa_norm_pkg.sv
  - verilog/norm_check.sv
  - verilog/norm_check_ctrl.sv
  - verilog/norm_check_top.sv
  - verilog/coeff_mem.sv
  - verilog/norm_check_apb_regs.sv
  - verilog/mldsa_norm_subsys.sv
  - target: test
    files:
      - testbench/norm_check_checker.sv
      - testbench/tb_mldsa_norm_subsys.sv
